// ==== ps2_kbd.f ====
design/ps2_proto_pkg.sv
design/kbd_bus_pkg.sv
design/ps2_line_sync.sv
design/ps2_link_rx.sv
design/ps2_xt_translate.sv
design/ps2_scan_decode.sv
design/ps2_kbd_wb.sv
bench/ps2_kbd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the PS/2 keyboard controller testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f ps2_kbd.f --top-module ps2_kbd_tb -o ps2_kbd_sim

# The log decides the result, so the run status is not used here
./obj_dir/ps2_kbd_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

// ==== bench/ps2_kbd_tb.sv ====
// Testbench for the PS/2 keyboard receive controller
// Clock and reset, keyboard frame driver, stimulus table,
// Wishbone read checks and interrupt counting

`timescale 1ns/1ps

module ps2_kbd_tb;

  localparam int WDOG       = 200;
  localparam int HALF_BIT   = 20;
  localparam int GAP_SHORT  = 40;
  // Longer than the watchdog plus the input delay
  localparam int GAP_LONG   = 300;
  localparam int IRQ_WAIT   = 2000;
  localparam int QUIET_WIN  = 600;
  localparam int NUM_ROWS   = 15;

  // One stimulus row
  typedef struct packed {
    logic [1:0] n_bytes;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [3:0] bits0;
    logic       bad_par;
    logic       irq;
    logic [7:0] exp;
  } row_t;

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  kbd_bus_pkg::wb_addr_t wb_adr_i;
  logic                  wb_stb_i;
  logic                  wb_cyc_i;
  logic                  ps2_clk_i;
  logic                  ps2_data_i;
  kbd_bus_pkg::wb_data_t wb_dat_o;
  logic                  wb_ack_o;
  logic                  wb_tgc_o;

  int pulse_cnt = 0;
  int start_cnt;

  // Bytes, first-byte bit count, bad parity, interrupt expected, data register
  row_t rows [NUM_ROWS] = '{
    '{2'd1, 8'h1C, 8'h00, 4'd11, 1'b0, 1'b1, 8'h1E},
    '{2'd1, 8'h32, 8'h00, 4'd11, 1'b0, 1'b1, 8'h30},
    '{2'd1, 8'h21, 8'h00, 4'd11, 1'b0, 1'b1, 8'h2E},
    '{2'd1, 8'h76, 8'h00, 4'd11, 1'b0, 1'b1, 8'h01},
    '{2'd1, 8'h5A, 8'h00, 4'd11, 1'b0, 1'b1, 8'h1C},
    '{2'd1, 8'h29, 8'h00, 4'd11, 1'b0, 1'b1, 8'h39},
    // Release of 1C
    '{2'd2, 8'hF0, 8'h1C, 4'd11, 1'b0, 1'b1, 8'h9E},
    // High codes pass unchanged
    '{2'd1, 8'hE0, 8'h00, 4'd11, 1'b0, 1'b1, 8'hE0},
    '{2'd1, 8'h83, 8'h00, 4'd11, 1'b0, 1'b1, 8'h83},
    // Shift keys trapped, register keeps 83
    '{2'd1, 8'h12, 8'h00, 4'd11, 1'b0, 1'b0, 8'h83},
    '{2'd1, 8'h59, 8'h00, 4'd11, 1'b0, 1'b0, 8'h83},
    '{2'd2, 8'hF0, 8'h12, 4'd11, 1'b0, 1'b0, 8'h83},
    // Bad parity dropped
    '{2'd1, 8'h5A, 8'h00, 4'd11, 1'b1, 1'b0, 8'h83},
    // Partial frame flushed by the watchdog, then a full one
    '{2'd2, 8'h1C, 8'h32, 4'd5,  1'b0, 1'b1, 8'h30},
    // Release of 76
    '{2'd2, 8'hF0, 8'h76, 4'd11, 1'b0, 1'b1, 8'h81}
  };

  ps2_kbd_wb #(
    .WDOG_CYCLES     (WDOG),
    .TRAP_SHIFT_KEYS (1)
  ) u_ps2_kbd_wb (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_adr_i   (wb_adr_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_data_i (ps2_data_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_tgc_o   (wb_tgc_o)
  );

  initial
  begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // Interrupt pulses seen so far
  always @(posedge wb_clk_i)
  begin
    if (wb_tgc_o === 1'b1)
      pulse_cnt <= pulse_cnt + 1;
  end

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped after a timeout");
  endtask

  // Keyboard side, data set while the clock is high
  task automatic send_frame(input logic [7:0] code, input logic bad_par, input int n_bits);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
    for (i = 0; i < n_bits; i++)
    begin
      @(negedge wb_clk_i);
      ps2_data_i = bits[i];
      repeat (HALF_BIT) @(negedge wb_clk_i);
      ps2_clk_i = 1'b0;
      repeat (HALF_BIT) @(negedge wb_clk_i);
      ps2_clk_i = 1'b1;
    end
    ps2_data_i = 1'b1;
  endtask

  // Single zero-wait read, ack checked during and after the access
  task automatic read_check(input kbd_bus_pkg::wb_addr_t adr, input logic [15:0] exp,
                            input string name);
    @(negedge wb_clk_i);
    wb_adr_i = adr;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    #1;
    compare("wb_ack_o", 16'(wb_ack_o), 16'h0001);
    compare(name, wb_dat_o, exp);
    @(negedge wb_clk_i);
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    #1;
    compare("wb_ack_o", 16'(wb_ack_o), 16'h0000);
  endtask

  task automatic wait_irq(input int base);
    int n;
    n = 0;
    while ((pulse_cnt == base) && (n < IRQ_WAIT))
    begin
      @(negedge wb_clk_i);
      n = n + 1;
    end
    if (pulse_cnt == base)
      timeout_fail("no interrupt within 2000 clock cycles");
  endtask

  initial
  begin
    wb_rst_i   = 1'b1;
    wb_adr_i   = 2'b00;
    wb_stb_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    ps2_clk_i  = 1'b1;
    ps2_data_i = 1'b1;
    repeat (2) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    // Reset values
    compare("wb_tgc_o", 16'(wb_tgc_o), 16'h0000);
    read_check(2'b00, 16'h0000, "data");
    read_check(2'b10, 16'h0010, "status");
    // Strobe without cycle is not acknowledged
    @(negedge wb_clk_i);
    wb_stb_i = 1'b1;
    #1;
    compare("wb_ack_o", 16'(wb_ack_o), 16'h0000);
    @(negedge wb_clk_i);
    wb_stb_i = 1'b0;
    // Nor is a cycle without strobe
    wb_cyc_i = 1'b1;
    #1;
    compare("wb_ack_o", 16'(wb_ack_o), 16'h0000);
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      start_cnt = pulse_cnt;
      send_frame(rows[r].b0, rows[r].bad_par, int'(rows[r].bits0));
      if (rows[r].bits0 < 4'd11)
        repeat (GAP_LONG) @(negedge wb_clk_i);
      else
        repeat (GAP_SHORT) @(negedge wb_clk_i);
      if (rows[r].n_bytes == 2'd2)
      begin
        send_frame(rows[r].b1, 1'b0, 11);
        repeat (GAP_SHORT) @(negedge wb_clk_i);
      end
      if (rows[r].irq)
        wait_irq(start_cnt);
      // Quiet window, catches extra or unexpected pulses
      repeat (QUIET_WIN) @(negedge wb_clk_i);
      compare("wb_tgc_o pulses", 16'(pulse_cnt - start_cnt), 16'(rows[r].irq));
      if (rows[r].irq)
      begin
        read_check(2'b10, 16'h0011, "status");
        read_check(2'b00, {8'h00, rows[r].exp}, "data");
        // OBF cleared by the data read
        read_check(2'b10, 16'h0010, "status");
      end
      else
      begin
        read_check(2'b10, 16'h0010, "status");
        read_check(2'b00, {8'h00, rows[r].exp}, "data");
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== design/ps2_kbd_wb.sv ====
// PS/2 keyboard receive controller with Wishbone slave port
// Read decode for data and status, OBF flag, interrupt register

`timescale 1ns/1ps

module ps2_kbd_wb #(
  parameter int WDOG_CYCLES     = 1920,
  parameter int TRAP_SHIFT_KEYS = 0
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  kbd_bus_pkg::wb_addr_t wb_adr_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_cyc_i,
  input  logic                  ps2_clk_i,
  input  logic                  ps2_data_i,
  output kbd_bus_pkg::wb_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_tgc_o
);

  ps2_proto_pkg::ps2_lines_t lines;
  ps2_proto_pkg::ps2_frame_t frame;
  ps2_proto_pkg::scan_code_t scancode;
  logic                      frame_done;
  logic                      key_strobe;
  logic                      obf_q;
  logic                      data_rd;
  kbd_bus_pkg::wb_data_t     status;

  ps2_line_sync u_ps2_line_sync (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_data_i (ps2_data_i),
    .lines_o    (lines)
  );

  ps2_link_rx #(
    .WDOG_CYCLES (WDOG_CYCLES)
  ) u_ps2_link_rx (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .lines_i      (lines),
    .frame_o      (frame),
    .frame_done_o (frame_done)
  );

  ps2_scan_decode #(
    .TRAP_SHIFT_KEYS (TRAP_SHIFT_KEYS)
  ) u_ps2_scan_decode (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .frame_i      (frame),
    .frame_done_i (frame_done),
    .scancode_o   (scancode),
    .key_strobe_o (key_strobe)
  );

  // Zero wait state slave
  assign wb_ack_o = wb_stb_i && wb_cyc_i;
  assign data_rd  = wb_ack_o && !wb_adr_i[kbd_bus_pkg::REG_STATUS_BIT];

  // Status word, everything not listed reads 0
  always_comb
  begin
    status = '0;
    status[kbd_bus_pkg::STAT_OBF]      = obf_q;
    status[kbd_bus_pkg::STAT_UNLOCKED] = 1'b1;
  end

  assign wb_dat_o = wb_adr_i[kbd_bus_pkg::REG_STATUS_BIT] ? status : {8'h00, scancode};

  // New key beats a read in the same cycle
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      obf_q <= 1'b0;
    else if (key_strobe)
      obf_q <= 1'b1;
    else if (data_rd)
      obf_q <= 1'b0;
  end

  // Interrupt pulse, one cycle per key
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      wb_tgc_o <= 1'b0;
    else
      wb_tgc_o <= key_strobe;
  end

endmodule

// ==== design/ps2_scan_decode.sv ====
// Scan code decode after the link layer
// Release prefix tracking, shift trap, data register, key strobe

`timescale 1ns/1ps

module ps2_scan_decode #(
  parameter int TRAP_SHIFT_KEYS = 0
) (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  ps2_proto_pkg::ps2_frame_t frame_i,
  input  logic                      frame_done_i,
  output ps2_proto_pkg::scan_code_t scancode_o,
  output logic                      key_strobe_o
);

  ps2_proto_pkg::xt_code_t xt_code;
  logic                    release_q;
  logic                    good_frame;
  logic                    is_release;
  logic                    is_trapped;

  ps2_xt_translate u_ps2_xt_translate (
    .at_code_i (frame_i.code[6:0]),
    .xt_code_o (xt_code)
  );

  assign good_frame = frame_done_i && frame_i.frame_ok;
  assign is_release = (frame_i.code == ps2_proto_pkg::RELEASE_CODE);
  // Shift keys swallowed, both make and break
  assign is_trapped = (TRAP_SHIFT_KEYS != 0) &&
                      ((frame_i.code == ps2_proto_pkg::LEFT_SHIFT) ||
                       (frame_i.code == ps2_proto_pkg::RIGHT_SHIFT));

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      release_q    <= 1'b0;
      scancode_o   <= '0;
      key_strobe_o <= 1'b0;
    end
    else
    begin
      key_strobe_o <= 1'b0;
      if (good_frame && is_release)
        release_q <= 1'b1;
      else if (good_frame && (frame_i.code != '0))
      begin
        // Prefix consumed by whatever code follows it
        release_q <= 1'b0;
        if (!is_trapped)
        begin
          // E0, E1 and other high codes go out raw
          if (frame_i.code[7])
            scancode_o <= frame_i.code;
          else
            scancode_o <= {release_q, xt_code};
          key_strobe_o <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/ps2_xt_translate.sv ====
// Scan set 2 to set 1 translation table
// Make codes below 0x80 only, unmapped codes give 00

`timescale 1ns/1ps

module ps2_xt_translate (
  input  logic [6:0]              at_code_i,
  output ps2_proto_pkg::xt_code_t xt_code_o
);

  always_comb
  begin
    case (at_code_i)
      // Function keys
      7'h01: xt_code_o = 7'h43;
      7'h03: xt_code_o = 7'h3F;
      7'h04: xt_code_o = 7'h3D;
      7'h05: xt_code_o = 7'h3B;
      7'h06: xt_code_o = 7'h3C;
      7'h07: xt_code_o = 7'h58;
      7'h09: xt_code_o = 7'h44;
      7'h0A: xt_code_o = 7'h42;
      7'h0B: xt_code_o = 7'h40;
      7'h0C: xt_code_o = 7'h3E;
      7'h0D: xt_code_o = 7'h0F;
      7'h0E: xt_code_o = 7'h29;
      // Left modifiers and first letter rows
      7'h11: xt_code_o = 7'h38;
      7'h12: xt_code_o = 7'h2A;
      7'h14: xt_code_o = 7'h1D;
      7'h15: xt_code_o = 7'h10;
      7'h16: xt_code_o = 7'h02;
      7'h1A: xt_code_o = 7'h2C;
      7'h1B: xt_code_o = 7'h1F;
      7'h1C: xt_code_o = 7'h1E;
      7'h1D: xt_code_o = 7'h11;
      7'h1E: xt_code_o = 7'h03;
      7'h21: xt_code_o = 7'h2E;
      7'h22: xt_code_o = 7'h2D;
      7'h23: xt_code_o = 7'h20;
      7'h24: xt_code_o = 7'h12;
      7'h25: xt_code_o = 7'h05;
      7'h26: xt_code_o = 7'h04;
      // Space
      7'h29: xt_code_o = 7'h39;
      7'h2A: xt_code_o = 7'h2F;
      7'h2B: xt_code_o = 7'h21;
      7'h2C: xt_code_o = 7'h14;
      7'h2D: xt_code_o = 7'h13;
      7'h2E: xt_code_o = 7'h06;
      7'h31: xt_code_o = 7'h31;
      7'h32: xt_code_o = 7'h30;
      7'h33: xt_code_o = 7'h23;
      7'h34: xt_code_o = 7'h22;
      7'h35: xt_code_o = 7'h15;
      7'h36: xt_code_o = 7'h07;
      7'h3A: xt_code_o = 7'h32;
      7'h3B: xt_code_o = 7'h24;
      7'h3C: xt_code_o = 7'h16;
      7'h3D: xt_code_o = 7'h08;
      7'h3E: xt_code_o = 7'h09;
      7'h41: xt_code_o = 7'h33;
      7'h42: xt_code_o = 7'h25;
      7'h43: xt_code_o = 7'h17;
      7'h44: xt_code_o = 7'h18;
      7'h45: xt_code_o = 7'h0B;
      7'h46: xt_code_o = 7'h0A;
      7'h49: xt_code_o = 7'h34;
      7'h4A: xt_code_o = 7'h35;
      7'h4B: xt_code_o = 7'h26;
      7'h4C: xt_code_o = 7'h27;
      7'h4D: xt_code_o = 7'h19;
      7'h4E: xt_code_o = 7'h0C;
      7'h52: xt_code_o = 7'h28;
      7'h54: xt_code_o = 7'h1A;
      7'h55: xt_code_o = 7'h0D;
      // Caps lock, right shift, enter
      7'h58: xt_code_o = 7'h3A;
      7'h59: xt_code_o = 7'h36;
      7'h5A: xt_code_o = 7'h1C;
      7'h5B: xt_code_o = 7'h1B;
      7'h5D: xt_code_o = 7'h2B;
      // Extra key on 102-key boards
      7'h61: xt_code_o = 7'h56;
      7'h66: xt_code_o = 7'h0E;
      // Keypad block
      7'h69: xt_code_o = 7'h4F;
      7'h6B: xt_code_o = 7'h4B;
      7'h6C: xt_code_o = 7'h47;
      7'h70: xt_code_o = 7'h52;
      7'h71: xt_code_o = 7'h53;
      7'h72: xt_code_o = 7'h50;
      7'h73: xt_code_o = 7'h4C;
      7'h74: xt_code_o = 7'h4D;
      7'h75: xt_code_o = 7'h48;
      7'h76: xt_code_o = 7'h01;
      7'h77: xt_code_o = 7'h45;
      7'h78: xt_code_o = 7'h57;
      7'h79: xt_code_o = 7'h4E;
      7'h7A: xt_code_o = 7'h51;
      7'h7B: xt_code_o = 7'h4A;
      7'h7C: xt_code_o = 7'h37;
      7'h7D: xt_code_o = 7'h49;
      7'h7E: xt_code_o = 7'h46;
      default: xt_code_o = 7'h00;
    endcase
  end

endmodule

// ==== design/ps2_link_rx.sv ====
// PS/2 receive link layer
// Edge tracking FSM, bit counter, shift register,
// 60 us watchdog and start/parity/stop check

`timescale 1ns/1ps

module ps2_link_rx #(
  parameter int WDOG_CYCLES = 1920
) (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  ps2_proto_pkg::ps2_lines_t lines_i,
  output ps2_proto_pkg::ps2_frame_t frame_o,
  output logic                      frame_done_o
);

  // Watchdog counts up to WDOG_CYCLES - 1
  localparam int WDOG_W = $clog2(WDOG_CYCLES + 1);
  // Bit counter must hold FRAME_BITS itself
  localparam int CNT_W  = $clog2(ps2_proto_pkg::FRAME_BITS + 1);

  ps2_proto_pkg::link_state_t state_q;
  ps2_proto_pkg::link_state_t state_d;

  logic [CNT_W-1:0]                     bit_cnt_q;
  logic [ps2_proto_pkg::FRAME_BITS-1:0] shift_q;
  logic [WDOG_W-1:0]                    wdog_cnt_q;

  logic wdog_run;
  logic wdog_done;
  logic frame_full;
  logic start_ok;
  logic parity_ok;
  logic stop_ok;

  // Watchdog only runs while the clock sits high between bits
  assign wdog_run   = (state_q == ps2_proto_pkg::idle_high) && lines_i.clk;
  assign wdog_done  = (wdog_cnt_q == WDOG_W'(WDOG_CYCLES - 1));
  assign frame_full = (bit_cnt_q == CNT_W'(ps2_proto_pkg::FRAME_BITS));

  // Next state from the filtered clock level
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ps2_proto_pkg::idle_high:
      begin
        if (!lines_i.clk)
          state_d = ps2_proto_pkg::fall_mark;
      end
      ps2_proto_pkg::fall_mark:
      begin
        state_d = ps2_proto_pkg::clk_low;
      end
      ps2_proto_pkg::clk_low:
      begin
        if (lines_i.clk)
          state_d = ps2_proto_pkg::rise_mark;
      end
      ps2_proto_pkg::rise_mark:
      begin
        state_d = ps2_proto_pkg::idle_high;
      end
      default:
      begin
        state_d = ps2_proto_pkg::idle_high;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      state_q <= ps2_proto_pkg::idle_high;
    else
      state_q <= state_d;
  end

  // Watchdog timer, saturates at its end value
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || !wdog_run)
      wdog_cnt_q <= '0;
    else if (!wdog_done)
      wdog_cnt_q <= wdog_cnt_q + 1'b1;
  end

  // Bit counter
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || frame_full)
      bit_cnt_q <= '0;
    else if (wdog_run && wdog_done)
      // Clock high too long, drop the partial frame
      bit_cnt_q <= '0;
    else if (state_q == ps2_proto_pkg::fall_mark)
      bit_cnt_q <= bit_cnt_q + 1'b1;
  end

  // LSB first, start bit ends up in bit 0
  always_ff @(posedge wb_clk_i)
  begin
    if (state_q == ps2_proto_pkg::fall_mark)
      shift_q <= {lines_i.data, shift_q[ps2_proto_pkg::FRAME_BITS-1:1]};
  end

  // Frame check
  assign start_ok  = !shift_q[0];
  // Odd parity over data and parity bits
  assign parity_ok = ^shift_q[9:1];
  assign stop_ok   = shift_q[ps2_proto_pkg::FRAME_BITS-1];

  assign frame_o.code     = shift_q[8:1];
  assign frame_o.frame_ok = start_ok && parity_ok && stop_ok;
  // High for the single cycle the counter holds FRAME_BITS
  assign frame_done_o     = frame_full;

endmodule

// ==== design/ps2_line_sync.sv ====
// Input conditioning for the PS/2 clock and data lines
// Two-flop synchronizer followed by a 2-of-3 majority filter

`timescale 1ns/1ps

module ps2_line_sync (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  logic                      ps2_clk_i,
  input  logic                      ps2_data_i,
  output ps2_proto_pkg::ps2_lines_t lines_o
);

  // Synchronizer stages
  ps2_proto_pkg::ps2_lines_t meta_q;
  ps2_proto_pkg::ps2_lines_t sync_q;
  // Two older samples for the vote
  ps2_proto_pkg::ps2_lines_t hist1_q;
  ps2_proto_pkg::ps2_lines_t hist2_q;
  ps2_proto_pkg::ps2_lines_t vote;

  // Bitwise majority, each line voted on its own
  assign vote = (sync_q & hist1_q) | (sync_q & hist2_q) | (hist1_q & hist2_q);

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      // Lines idle high, so start from all ones
      meta_q  <= '1;
      sync_q  <= '1;
      hist1_q <= '1;
      hist2_q <= '1;
      lines_o <= '1;
    end
    else
    begin
      meta_q  <= '{clk: ps2_clk_i, data: ps2_data_i};
      sync_q  <= meta_q;
      hist1_q <= sync_q;
      hist2_q <= hist1_q;
      // Filter register, third cycle of delay
      lines_o <= vote;
    end
  end

endmodule

// ==== design/kbd_bus_pkg.sv ====
// Wishbone side definitions of the keyboard controller
// Bus data and address types, register select and status bits

package kbd_bus_pkg;

  // Read data width of the slave port
  typedef logic [15:0] wb_data_t;

  // Word address, byte lane bit 0 not present
  typedef logic [2:1] wb_addr_t;

  // Address bit that picks the status register
  localparam int REG_STATUS_BIT = 2;

  // Output buffer full
  localparam int STAT_OBF = 0;

  // Keyboard not inhibited, reads back as 1
  localparam int STAT_UNLOCKED = 4;

endpackage

// ==== design/ps2_proto_pkg.sv ====
// PS/2 protocol definitions
// Line, frame and scan code types, protocol constants
// and the receive state encoding

package ps2_proto_pkg;

  // Raw byte as shifted in from the keyboard
  typedef logic [7:0] scan_code_t;

  // Set 1 code without the release bit
  typedef logic [6:0] xt_code_t;

  // Filtered levels of the two PS/2 lines
  typedef struct packed {
    logic clk;
    logic data;
  } ps2_lines_t;

  // Received byte plus the result of the frame check
  typedef struct packed {
    scan_code_t code;
    logic       frame_ok;
  } ps2_frame_t;

  // Receive FSM, edge markers last one cycle each
  typedef enum logic [1:0] {
    idle_high,
    fall_mark,
    clk_low,
    rise_mark
  } link_state_t;

  // Special codes from the keyboard
  localparam scan_code_t RELEASE_CODE = 8'hF0;
  localparam scan_code_t LEFT_SHIFT   = 8'h12;
  localparam scan_code_t RIGHT_SHIFT  = 8'h59;

  // Start, 8 data, parity, stop
  localparam int FRAME_BITS = 11;

endpackage
